/* rtl/dma_defines.svh */
/* DMA front end configuration
   Group count, interleave geometry and bus widths of the cluster */

`ifndef DMA_DEFINES_SVH
`define DMA_DEFINES_SVH

// Cluster geometry
`define DMA_NUM_GROUPS 4
`define DMA_BANKS_PER_GROUP 16

// Bytes one group owns in each interleave step of 4-byte banks
`define DMA_REGION_BYTES (`DMA_BANKS_PER_GROUP * 4)
`define DMA_CLUSTER_REGION_BYTES (`DMA_REGION_BYTES * `DMA_NUM_GROUPS)

// Bus widths
`define DMA_ADDR_WIDTH 32
`define DMA_LEN_WIDTH 32

// Handshakes per cycle fit in this many bits
`define DMA_ISSUE_WIDTH ($clog2(`DMA_NUM_GROUPS + 1))

`endif

/* rtl/dma_pkg.sv */
/* DMA front end types
   Burst request, chunk and status records shared by all blocks */

`include "dma_defines.svh"

`default_nettype none

package dma_pkg;

  typedef logic [`DMA_ADDR_WIDTH-1:0] addr_t;
  typedef logic [`DMA_LEN_WIDTH-1:0]  len_t;

  // One burst or piece of a burst
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_bytes;
  } dma_req_t;

  // Region-bounded part of a burst
  typedef struct packed {
    dma_req_t req;
    logic     last;
  } dma_chunk_t;

  typedef struct packed {
    logic backend_idle;
    logic trans_complete;
  } dma_meta_t;

  typedef logic [$clog2(`DMA_NUM_GROUPS)-1:0] group_idx_t;

endpackage : dma_pkg

`default_nettype wire

/* rtl/spill_register.sv */
/* Spill register
   Two-slot ready/valid buffer with registered data and ready paths */

`default_nettype none

module spill_register #(
  parameter type T = logic
) (
  input  wire logic clk_i,
  input  wire logic rst_i,
  input  wire logic valid_i,
  output logic      ready_o,
  input  wire T     data_i,
  output logic      valid_o,
  input  wire logic ready_i,
  output T          data_o
);

  logic a_full_q, b_full_q;
  T     a_data_q, b_data_q;
  logic a_fill, a_drain, b_fill, b_drain;

  // Slot A takes new data, slot B catches A when the output stalls
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  // B always holds the older item
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill | a_drain) begin
        a_full_q <= a_fill;
      end
      if (b_fill | b_drain) begin
        b_full_q <= b_fill;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

endmodule : spill_register

`default_nettype wire

/* rtl/dma_burst_splitter.sv */
/* DMA burst splitter
   Cuts one burst into chunks that stay inside one cluster region */

`include "dma_defines.svh"

`default_nettype none

module dma_burst_splitter (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire dma_pkg::dma_req_t req_i,
  input  wire logic              valid_i,
  output logic                   ready_o,
  input  wire logic              burst_open_i,
  output dma_pkg::dma_chunk_t    chunk_o,
  output logic                   valid_o,
  input  wire logic              ready_i,
  output logic                   busy_o
);

  import dma_pkg::*;

  localparam len_t RegionBytes = len_t'(`DMA_CLUSTER_REGION_BYTES);

  logic  active_q;
  addr_t src_q;
  addr_t dst_q;
  len_t  left_q;
  len_t  to_boundary;
  len_t  chunk_len;
  logic  accept;
  logic  advance;

  // Distance from dst up to the next region boundary
  assign to_boundary = RegionBytes - (len_t'(dst_q) & (RegionBytes - 1));
  assign chunk_len   = (left_q < to_boundary) ? left_q : to_boundary;

  always_comb begin
    chunk_o.req.src       = src_q;
    chunk_o.req.dst       = dst_q;
    chunk_o.req.num_bytes = chunk_len;
    // Also covers the zero-length burst
    chunk_o.last          = (left_q == chunk_len);
  end

  // Only one burst in flight
  assign ready_o = ~active_q & ~burst_open_i;
  assign valid_o = active_q;
  assign busy_o  = active_q;

  assign accept  = valid_i & ready_o;
  assign advance = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      active_q <= 1'b0;
    end else if (accept) begin
      active_q <= 1'b1;
    end else if (advance && chunk_o.last) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      src_q  <= req_i.src;
      dst_q  <= req_i.dst;
      left_q <= req_i.num_bytes;
    end else if (advance) begin
      src_q  <= src_q + addr_t'(chunk_len);
      dst_q  <= dst_q + addr_t'(chunk_len);
      left_q <= left_q - chunk_len;
    end
  end

endmodule : dma_burst_splitter

`default_nettype wire

/* rtl/dma_group_distributor.sv */
/* DMA group distributor
   Cuts a chunk into one piece per group window and offers all lanes at once */

`include "dma_defines.svh"

`default_nettype none

module dma_group_distributor (
  input  wire logic                                clk_i,
  input  wire logic                                rst_i,
  input  wire dma_pkg::dma_chunk_t                 chunk_i,
  input  wire logic                                valid_i,
  output logic                                     ready_o,
  output dma_pkg::dma_req_t [`DMA_NUM_GROUPS-1:0]  group_req_o,
  output logic [`DMA_NUM_GROUPS-1:0]               group_valid_o,
  input  wire logic [`DMA_NUM_GROUPS-1:0]          group_ready_i,
  output logic [`DMA_ISSUE_WIDTH-1:0]              issue_count_o,
  output logic                                     burst_end_o,
  output logic                                     busy_o
);

  import dma_pkg::*;

  localparam int    NumGroups    = `DMA_NUM_GROUPS;
  localparam int    IssueWidth   = `DMA_ISSUE_WIDTH;
  localparam addr_t WindowBytes  = addr_t'(`DMA_REGION_BYTES);
  localparam addr_t ClusterBytes = addr_t'(`DMA_CLUSTER_REGION_BYTES);

  dma_req_t [NumGroups-1:0] piece_d, piece_q;
  logic     [NumGroups-1:0] pending_d, pending_q;
  logic     [NumGroups-1:0] lane_hs;
  logic                     held_q;
  logic                     last_q;
  logic                     chunk_done;
  logic                     accept;

  // Overlap of the chunk with each group window of its cluster region
  always_comb begin : split_pieces
    addr_t base;
    addr_t chunk_end;
    addr_t win_lo;
    addr_t win_hi;
    addr_t lo;
    addr_t hi;
    base      = chunk_i.req.dst & ~(ClusterBytes - 1);
    chunk_end = chunk_i.req.dst + addr_t'(chunk_i.req.num_bytes);
    for (int g = 0; g < NumGroups; g++) begin
      win_lo = base + addr_t'(group_idx_t'(g)) * WindowBytes;
      win_hi = win_lo + WindowBytes;
      lo = (chunk_i.req.dst > win_lo) ? chunk_i.req.dst : win_lo;
      hi = (chunk_end < win_hi) ? chunk_end : win_hi;
      piece_d[g].dst       = lo;
      piece_d[g].src       = chunk_i.req.src + (lo - chunk_i.req.dst);
      piece_d[g].num_bytes = (hi > lo) ? len_t'(hi - lo) : '0;
      pending_d[g]         = (hi > lo);
    end
  end

  assign lane_hs    = pending_q & group_ready_i;
  // Every lane still pending handshakes this cycle
  assign chunk_done = ((pending_q & ~group_ready_i) == '0);
  assign ready_o    = ~held_q | chunk_done;
  assign accept     = valid_i & ready_o;

  always_comb begin
    issue_count_o = '0;
    for (int g = 0; g < NumGroups; g++) begin
      issue_count_o = issue_count_o + IssueWidth'(lane_hs[g]);
    end
  end

  assign burst_end_o   = held_q & last_q & chunk_done;
  assign busy_o        = held_q;
  assign group_valid_o = pending_q;
  assign group_req_o   = piece_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      held_q    <= 1'b0;
      last_q    <= 1'b0;
      pending_q <= '0;
    end else if (accept) begin
      held_q    <= 1'b1;
      last_q    <= chunk_i.last;
      pending_q <= pending_d;
    end else begin
      pending_q <= pending_q & ~lane_hs;
      if (chunk_done) begin
        held_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      piece_q <= piece_d;
    end
  end

endmodule : dma_group_distributor

`default_nettype wire

/* rtl/dma_completion_tracker.sv */
/* DMA completion tracker
   Counts outstanding pieces and registers the cluster DMA status */

`include "dma_defines.svh"

`default_nettype none

module dma_completion_tracker (
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,
  input  wire logic [`DMA_ISSUE_WIDTH-1:0]   issue_count_i,
  input  wire logic                          burst_end_i,
  input  wire logic [`DMA_NUM_GROUPS-1:0]    group_done_i,
  // Bit 1 splitter, bit 0 distributor
  input  wire logic [1:0]                    path_busy_i,
  output logic                               burst_open_o,
  output dma_pkg::dma_meta_t                 dma_meta_o
);

  import dma_pkg::*;

  localparam int IssueWidth = `DMA_ISSUE_WIDTH;

  logic [IssueWidth-1:0] done_count;
  len_t                  count_q, count_d;
  logic                  armed_q, armed_d;
  logic                  fire;
  logic                  idle_d;

  always_comb begin
    done_count = '0;
    for (int g = 0; g < `DMA_NUM_GROUPS; g++) begin
      done_count = done_count + IssueWidth'(group_done_i[g]);
    end
    count_d = count_q + len_t'(issue_count_i) - len_t'(done_count);
    armed_d = armed_q | burst_end_i;
    // Last piece of an ended burst has completed
    fire    = armed_d & (count_d == '0);
    idle_d  = ~(armed_d & ~fire) & (count_d == '0) & (path_busy_i == '0);
  end

  assign burst_open_o = armed_q | (count_q != '0) | (|path_busy_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      count_q                   <= '0;
      armed_q                   <= 1'b0;
      dma_meta_o.backend_idle   <= 1'b1;
      dma_meta_o.trans_complete <= 1'b0;
    end else begin
      count_q                   <= count_d;
      armed_q                   <= armed_d & ~fire;
      dma_meta_o.backend_idle   <= idle_d;
      dma_meta_o.trans_complete <= fire;
    end
  end

endmodule : dma_completion_tracker

`default_nettype wire

/* rtl/dma_cluster_frontend.sv */
/* DMA cluster front end
   Request register, burst splitter, group distributor and completion tracker */

`include "dma_defines.svh"

`default_nettype none

module dma_cluster_frontend (
  input  wire logic                                    clk_i,
  input  wire logic                                    rst_i,
  input  wire dma_pkg::dma_req_t                       dma_req_i,
  input  wire logic                                    dma_req_valid_i,
  output logic                                         dma_req_ready_o,
  output dma_pkg::dma_req_t [`DMA_NUM_GROUPS-1:0]      group_req_o,
  output logic [`DMA_NUM_GROUPS-1:0]                   group_valid_o,
  input  wire logic [`DMA_NUM_GROUPS-1:0]              group_ready_i,
  input  wire logic [`DMA_NUM_GROUPS-1:0]              group_done_i,
  output dma_pkg::dma_meta_t                           dma_meta_o
);

  import dma_pkg::*;

  dma_req_t                    req_cut;
  logic                        req_cut_valid, req_cut_ready;
  dma_chunk_t                  chunk;
  logic                        chunk_valid, chunk_ready;
  logic [`DMA_ISSUE_WIDTH-1:0] issue_count;
  logic                        burst_end, burst_open;
  logic                        split_busy, dist_busy;

  spill_register #(
    .T(dma_req_t)
  ) i_req_register (
    .clk_i  (clk_i          ),
    .rst_i  (rst_i          ),
    .valid_i(dma_req_valid_i),
    .ready_o(dma_req_ready_o),
    .data_i (dma_req_i      ),
    .valid_o(req_cut_valid  ),
    .ready_i(req_cut_ready  ),
    .data_o (req_cut        )
  );

  dma_burst_splitter i_burst_splitter (
    .clk_i       (clk_i        ),
    .rst_i       (rst_i        ),
    .req_i       (req_cut      ),
    .valid_i     (req_cut_valid),
    .ready_o     (req_cut_ready),
    .burst_open_i(burst_open   ),
    .chunk_o     (chunk        ),
    .valid_o     (chunk_valid  ),
    .ready_i     (chunk_ready  ),
    .busy_o      (split_busy   )
  );

  dma_group_distributor i_group_distributor (
    .clk_i        (clk_i        ),
    .rst_i        (rst_i        ),
    .chunk_i      (chunk        ),
    .valid_i      (chunk_valid  ),
    .ready_o      (chunk_ready  ),
    .group_req_o  (group_req_o  ),
    .group_valid_o(group_valid_o),
    .group_ready_i(group_ready_i),
    .issue_count_o(issue_count  ),
    .burst_end_o  (burst_end    ),
    .busy_o       (dist_busy    )
  );

  dma_completion_tracker i_completion_tracker (
    .clk_i        (clk_i                   ),
    .rst_i        (rst_i                   ),
    .issue_count_i(issue_count             ),
    .burst_end_i  (burst_end               ),
    .group_done_i (group_done_i            ),
    .path_busy_i  ({split_busy, dist_busy} ),
    .burst_open_o (burst_open              ),
    .dma_meta_o   (dma_meta_o              )
  );

endmodule : dma_cluster_frontend

`default_nettype wire

/* test/dma_checker.sv */
/* DMA front end checker
   Predicts group pieces and status from the DMA ports and counts errors */

`include "dma_defines.svh"

`default_nettype none

module dma_checker (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_i,
  input  wire logic                                   end_i,
  input  wire dma_pkg::dma_req_t                      dma_req_i,
  input  wire logic                                   dma_req_valid_i,
  input  wire logic                                   dma_req_ready_i,
  input  wire dma_pkg::dma_req_t [`DMA_NUM_GROUPS-1:0] group_req_i,
  input  wire logic [`DMA_NUM_GROUPS-1:0]             group_valid_i,
  input  wire logic [`DMA_NUM_GROUPS-1:0]             group_ready_i,
  input  wire logic [`DMA_NUM_GROUPS-1:0]             group_done_i,
  input  wire dma_pkg::dma_meta_t                     dma_meta_i,
  output int                                          error_count_o,
  output int                                          burst_count_o,
  output int                                          piece_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import dma_pkg::*;

  typedef logic [63:0] wide_t;

  typedef struct packed {
    group_idx_t group;
    dma_req_t   req;
  } piece_t;

  localparam int    NumGroups   = `DMA_NUM_GROUPS;
  localparam wide_t WindowBytes = wide_t'(`DMA_REGION_BYTES);
  localparam wide_t RegionBytes = wide_t'(`DMA_CLUSTER_REGION_BYTES);

  piece_t      expected_q[$];
  logic [31:0] exp_bytes[NumGroups];
  logic [31:0] act_bytes[NumGroups];
  int          in_flight[NumGroups];
  int          open_bursts;
  logic        reset_seen;
  logic        idle_due;

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch at %0t: %s expected 0x%0h actual 0x%0h", $time, name, expected,
               actual);
      error_count_o++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("error at %0t: %s", $time, msg);
    error_count_o++;
  endtask

  function automatic int outstanding();
    int total;
    total = 0;
    for (int g = 0; g < NumGroups; g++) begin
      total += in_flight[g];
    end
    return total;
  endfunction

  // Region-bounded chunks, then the overlap with each group window
  task automatic predict_burst(input dma_req_t req);
    wide_t  src;
    wide_t  dst;
    wide_t  left;
    wide_t  clen;
    wide_t  region;
    wide_t  lo;
    wide_t  hi;
    piece_t piece;
    src  = wide_t'(req.src);
    dst  = wide_t'(req.dst);
    left = wide_t'(req.num_bytes);
    while (left != '0) begin
      region = dst - (dst % RegionBytes);
      clen   = region + RegionBytes - dst;
      if (left < clen) begin
        clen = left;
      end
      for (int g = 0; g < NumGroups; g++) begin
        lo = region + wide_t'(g) * WindowBytes;
        hi = lo + WindowBytes;
        if (dst > lo) begin
          lo = dst;
        end
        if (dst + clen < hi) begin
          hi = dst + clen;
        end
        if (hi > lo) begin
          piece.group         = group_idx_t'(g);
          piece.req.src       = addr_t'(src + (lo - dst));
          piece.req.dst       = addr_t'(lo);
          piece.req.num_bytes = len_t'(hi - lo);
          expected_q.push_back(piece);
          exp_bytes[g] = exp_bytes[g] + 32'(hi - lo);
        end
      end
      src  = src + clen;
      dst  = dst + clen;
      left = left - clen;
    end
  endtask

  // Oldest predicted piece of this group must match
  task automatic check_piece(input int g);
    int idx;
    idx = -1;
    for (int i = 0; i < expected_q.size(); i++) begin
      if (idx < 0 && expected_q[i].group == group_idx_t'(g)) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      report_error($sformatf("unexpected piece on group %0d", g));
    end else begin
      compare_value($sformatf("group_req_o[%0d].src", g), expected_q[idx].req.src,
                    group_req_i[g].src);
      compare_value($sformatf("group_req_o[%0d].dst", g), expected_q[idx].req.dst,
                    group_req_i[g].dst);
      compare_value($sformatf("group_req_o[%0d].num_bytes", g),
                    expected_q[idx].req.num_bytes, group_req_i[g].num_bytes);
      expected_q.delete(idx);
    end
    in_flight[g]++;
    act_bytes[g] = act_bytes[g] + group_req_i[g].num_bytes;
    piece_count_o++;
  endtask

  // Sampled mid-cycle, a valid and ready pair transfers at the next edge
  always @(negedge clk_i) begin : monitor
    if (rst_i) begin
      expected_q.delete();
      for (int g = 0; g < NumGroups; g++) begin
        exp_bytes[g] = '0;
        act_bytes[g] = '0;
        in_flight[g] = 0;
      end
      open_bursts   = 0;
      error_count_o = 0;
      burst_count_o = 0;
      piece_count_o = 0;
      reset_seen    = 1'b1;
      idle_due      = 1'b0;
    end else begin
      if (reset_seen) begin
        compare_value("dma_meta_o.backend_idle", 32'd1, 32'(dma_meta_i.backend_idle));
        compare_value("dma_meta_o.trans_complete", 32'd0, 32'(dma_meta_i.trans_complete));
        compare_value("group_valid_o", 32'd0, 32'(group_valid_i));
        compare_value("dma_req_ready_o", 32'd1, 32'(dma_req_ready_i));
        reset_seen = 1'b0;
      end
      if (idle_due) begin
        compare_value("dma_meta_o.backend_idle", 32'd1, 32'(dma_meta_i.backend_idle));
        idle_due = 1'b0;
      end
      if (outstanding() > 0 && dma_meta_i.backend_idle) begin
        report_error("backend_idle is high while pieces are outstanding");
      end
      if (dma_meta_i.trans_complete) begin
        if (open_bursts == 0) begin
          report_error("trans_complete pulsed with no burst open");
        end else begin
          if (outstanding() != 0 || expected_q.size() != 0) begin
            report_error("trans_complete pulsed before all pieces were done");
          end
          open_bursts--;
          burst_count_o++;
        end
        idle_due = 1'b1;
      end
      if (dma_req_valid_i && dma_req_ready_i) begin
        predict_burst(dma_req_i);
        open_bursts++;
      end
      for (int g = 0; g < NumGroups; g++) begin
        if (group_valid_i[g] && group_ready_i[g]) begin
          check_piece(g);
        end
      end
      for (int g = 0; g < NumGroups; g++) begin
        if (group_done_i[g]) begin
          in_flight[g]--;
        end
      end
      if (end_i) begin
        if (expected_q.size() != 0) begin
          report_error($sformatf("%0d predicted pieces were never offered", expected_q.size()));
        end
        if (open_bursts != 0 || outstanding() != 0) begin
          report_error("a burst was still open at the end of the run");
        end
        for (int g = 0; g < NumGroups; g++) begin
          compare_value($sformatf("group_bytes[%0d]", g), exp_bytes[g], act_bytes[g]);
        end
      end
    end
  end

endmodule : dma_checker

`default_nettype wire

/* test/tb_dma_cluster.sv */
/* DMA cluster front end testbench
   Reads burst cases, drives the request port and models the groups */

`include "dma_defines.svh"

`default_nettype none

module tb_dma_cluster;

  timeunit 1ns;
  timeprecision 1ps;

  import dma_pkg::*;

  localparam int NumGroups = `DMA_NUM_GROUPS;
  localparam int WindowBytes = `DMA_REGION_BYTES;
  localparam int RegionBytes = `DMA_CLUSTER_REGION_BYTES;

  logic                     clk = 1'b0;
  logic                     rst = 1'b1;
  dma_req_t                 dma_req;
  logic                     dma_req_valid;
  logic                     dma_req_ready;
  dma_req_t [NumGroups-1:0] group_req;
  logic [NumGroups-1:0]     group_valid;
  logic [NumGroups-1:0]     group_ready;
  logic [NumGroups-1:0]     group_done;
  dma_meta_t                dma_meta;
  logic                     end_of_test;
  int                       check_errors;
  int                       burst_count;
  int                       piece_count;

  dma_req_t case_req[$];
  int       case_lat[$];
  int       case_idx = 0;
  int       cur_lat = 1;
  int       cycle = 0;
  int       cycle_limit = 1000;
  int       seed = 32'h56f8f264;

  always #50 clk = ~clk;

  dma_cluster_frontend dut0 (
    .clk_i          (clk          ),
    .rst_i          (rst          ),
    .dma_req_i      (dma_req      ),
    .dma_req_valid_i(dma_req_valid),
    .dma_req_ready_o(dma_req_ready),
    .group_req_o    (group_req    ),
    .group_valid_o  (group_valid  ),
    .group_ready_i  (group_ready  ),
    .group_done_i   (group_done   ),
    .dma_meta_o     (dma_meta     )
  );

  dma_checker chk0 (
    .clk_i          (clk          ),
    .rst_i          (rst          ),
    .end_i          (end_of_test  ),
    .dma_req_i      (dma_req      ),
    .dma_req_valid_i(dma_req_valid),
    .dma_req_ready_i(dma_req_ready),
    .group_req_i    (group_req    ),
    .group_valid_i  (group_valid  ),
    .group_ready_i  (group_ready  ),
    .group_done_i   (group_done   ),
    .dma_meta_i     (dma_meta     ),
    .error_count_o  (check_errors ),
    .burst_count_o  (burst_count  ),
    .piece_count_o  (piece_count  )
  );

  task automatic read_cases();
    int          fd;
    string       line;
    logic [31:0] src;
    logic [31:0] dst;
    logic [31:0] num;
    int          lat;
    dma_req_t    req;
    fd = $fopen("test/dma_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file test/dma_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0 && $sscanf(line, "%h %h %d %d", src, dst, num, lat) == 4) begin
          req.src       = src;
          req.dst       = dst;
          req.num_bytes = num;
          case_req.push_back(req);
          case_lat.push_back((lat < 1) ? 1 : lat);
        end
      end
      $fclose(fd);
    end
  endtask

  // Generous bound from the chunk and piece counts of the longest case
  task automatic set_cycle_limit();
    int span;
    int max_chunks;
    int max_pieces;
    int max_lat;
    max_chunks = 1;
    max_pieces = 1;
    max_lat    = 1;
    for (int i = 0; i < case_req.size(); i++) begin
      span = int'(case_req[i].dst % 32'(RegionBytes)) + int'(case_req[i].num_bytes);
      if (span / RegionBytes + 2 > max_chunks) begin
        max_chunks = span / RegionBytes + 2;
      end
      if (span / WindowBytes + 2 > max_pieces) begin
        max_pieces = span / WindowBytes + 2;
      end
      if (case_lat[i] > max_lat) begin
        max_lat = case_lat[i];
      end
    end
    cycle_limit = case_req.size() * (max_chunks + max_pieces * max_lat + 20);
  endtask

  task automatic send_burst(input dma_req_t req);
    @(posedge clk);
    #10;
    dma_req       = req;
    dma_req_valid = 1'b1;
    do begin
      @(negedge clk);
    end while (!dma_req_ready);
    @(posedge clk);
    #10;
    dma_req_valid = 1'b0;
    dma_req       = '0;
  endtask

  task automatic wait_complete();
    do begin
      @(negedge clk);
    end while (!dma_meta.trans_complete);
  endtask

  // Groups take pieces on random cycles and finish them in order
  initial begin : group_models
    int queued[NumGroups];
    int countdown[NumGroups];
    for (int g = 0; g < NumGroups; g++) begin
      queued[g]    = 0;
      countdown[g] = 0;
    end
    group_ready = '0;
    group_done  = '0;
    @(negedge rst);
    forever begin
      @(negedge clk);
      for (int g = 0; g < NumGroups; g++) begin
        if (group_valid[g] && group_ready[g]) begin
          queued[g]++;
        end
      end
      @(posedge clk);
      #10;
      for (int g = 0; g < NumGroups; g++) begin
        group_ready[g] = (($random(seed) & 3) != 0);
        group_done[g]  = 1'b0;
        if (queued[g] > 0) begin
          if (countdown[g] == 0) begin
            countdown[g] = 1 + (($random(seed) & 32'h7fff) % cur_lat);
          end
          countdown[g]--;
          if (countdown[g] == 0) begin
            group_done[g] = 1'b1;
            queued[g]--;
          end
        end
      end
    end
  end

  always @(posedge clk) begin : watchdog
    if (!rst) begin
      cycle = cycle + 1;
      if (cycle > cycle_limit) begin
        $display("Timeout after %0d cycles in burst %0d of %0d", cycle, case_idx + 1,
                 case_req.size());
        $display("Verification failed");
        $finish;
      end
    end
  end

  initial begin : main_sequence
    dma_req       = '0;
    dma_req_valid = 1'b0;
    end_of_test   = 1'b0;
    read_cases();
    if (case_req.size() == 0) begin
      $display("No cases found in test/dma_cases.txt");
      $display("Verification failed");
      $finish;
    end else begin
      set_cycle_limit();
      repeat (3) @(posedge clk);
      #10;
      rst = 1'b0;
      for (case_idx = 0; case_idx < case_req.size(); case_idx++) begin
        cur_lat = case_lat[case_idx];
        send_burst(case_req[case_idx]);
        wait_complete();
      end
      @(posedge clk);
      #10;
      end_of_test = 1'b1;
      @(negedge clk);
      #1;
      $display("Summary: %0d bursts, %0d pieces, %0d checker errors",
               burst_count, piece_count, check_errors);
      if (check_errors == 0) begin
        $display("Verification passed");
      end else begin
        $display("Verification failed");
      end
      $finish;
    end
  end

endmodule : tb_dma_cluster

`default_nettype wire

/* test/dma_cases.txt */
# src dst num_bytes max_latency
# src and dst in hex, num_bytes and group latency in cycles in decimal
80000000 00000010 32 2
80000100 00000048 16 1
80000200 000000c0 64 3
80001000 00000030 100 2
80002000 000000f0 300 4
80003000 00000100 0 2
90000004 00001004 1000 5
90001000 00000200 256 1
90002001 000003ff 2 1
90003000 00000500 0 1
a0000000 0000fff8 520 3
a0001000 000000fc 8 2
12345677 00000041 190 4
a0002000 00000000 1 1
b0000000 00000080 1536 2
b0004000 0000013f 129 6
c0000010 00002020 40 3
c0000100 00002040 192 2

/* src.f */
+incdir+rtl
rtl/dma_pkg.sv
rtl/spill_register.sv
rtl/dma_burst_splitter.sv
rtl/dma_group_distributor.sv
rtl/dma_completion_tracker.sv
rtl/dma_cluster_frontend.sv
test/dma_checker.sv
test/tb_dma_cluster.sv

/* run.sh */
#!/bin/sh
# Compile and run the DMA cluster front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f src.f \
  --top-module tb_dma_cluster --Mdir "$BUILD_DIR" -o tb_dma_cluster
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/tb_dma_cluster" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
